//--- flist.f
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_ctrl.sv
rtl/store_buffer.sv
rtl/dmem.sv
rtl/lsu_top.sv
sim/tb_lsu_top.sv

//--- rtl/dmem.sv
// Data memory with variable load latency
`timescale 1ns/1ps
`default_nettype none

module dmem
  import lsu_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     ld_valid_i,
  input  ld_req_t  ld_i,
  output logic     ld_ready_o,
  output logic     ldr_valid_o,
  output ld_rsp_t  ldr_o,
  input  logic     wr_valid_i,
  input  mem_wr_t  wr_i,
  output logic     wr_ready_o
);

  logic [XLEN-1:0]   mem_q [DMEM_WORDS];
  logic              busy_q;
  logic [1:0]        cnt_q;
  ld_req_t           ld_q;
  logic [PLEN-3:0]   ld_word;
  logic [PLEN-3:0]   wr_word;
  logic              ld_in_range;
  logic              wr_in_range;
  logic [3:0]        ld_mask;
  logic [3:0]        wr_mask;
  logic [XLEN-1:0]   ld_lanes;

  // Byte lanes touched by an access
  function automatic logic [3:0] lane_mask(input lsu_op_e op, input logic [1:0] off);
    case (op_size(op))
      2'd0:    lane_mask = 4'b0001 << off;
      2'd1:    lane_mask = 4'b0011 << off;
      default: lane_mask = 4'b1111;
    endcase
  endfunction

  assign ld_word     = ld_q.addr[PLEN-1:2];
  assign wr_word     = wr_i.addr[PLEN-1:2];
  assign ld_in_range = (ld_word < DMEM_WORDS);
  assign wr_in_range = (wr_word < DMEM_WORDS);
  assign ld_mask     = lane_mask(ld_q.op, ld_q.addr[1:0]);
  assign wr_mask     = lane_mask(wr_i.op, wr_i.addr[1:0]);

  // ----------------------------
  // Port arbitration
  // ----------------------------
  // Loads win, and an outstanding load keeps the array to itself
  assign ld_ready_o = !busy_q;
  assign wr_ready_o = !busy_q && !ld_valid_i;

  // Response fires when the counter runs out
  assign ldr_valid_o = busy_q && (cnt_q == 2'd0);

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      ld_lanes[8*b +: 8] = {8{ld_mask[b]}};
    end
  end

  assign ldr_o.err  = !ld_in_range;
  assign ldr_o.data = ld_in_range ? (mem_q[ld_word[DMEM_AW-1:0]] & ld_lanes) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (ld_valid_i && ld_ready_o) begin
      busy_q <= 1'b1;
      cnt_q  <= ld_i.addr[3:2];
    end else if (busy_q) begin
      if (cnt_q == 2'd0) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld_valid_i && ld_ready_o) begin
      ld_q <= ld_i;
    end
  end

  // Array starts at zero, out of range writes are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < DMEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (wr_valid_i && wr_ready_o && wr_in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_mask[b]) begin
          mem_q[wr_word[DMEM_AW-1:0]][8*b +: 8] <= wr_i.data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/lsu_agu.sv
// LSU address generation unit
`timescale 1ns/1ps
`default_nettype none

module lsu_agu
  import lsu_pkg::*;
(
  input  lsu_op_e          op_i,
  input  logic [XLEN-1:0]  rs1_i,
  input  logic [XLEN-1:0]  imm_i,
  input  logic [XLEN-1:0]  raw_i,
  output logic [PLEN-1:0]  addr_o,
  output logic             misaligned_o,
  output logic [XLEN-1:0]  data_o
);

  logic [XLEN-1:0] eff_addr;
  logic [XLEN-1:0] shifted;

  // Only the low PLEN bits reach the memory system
  assign eff_addr = rs1_i + imm_i;
  assign addr_o   = eff_addr[PLEN-1:0];

  always_comb begin
    case (op_size(op_i))
      2'd0:    misaligned_o = 1'b0;
      2'd1:    misaligned_o = addr_o[0];
      default: misaligned_o = |addr_o[1:0];
    endcase
  end

  // ----------------------------
  // Load data extraction
  // ----------------------------
  // Bring the addressed byte lane down to bit 0
  assign shifted = raw_i >> {addr_o[1:0], 3'b000};

  always_comb begin
    case (op_i)
      LSU_LB:  data_o = {{(XLEN - 8){shifted[7]}}, shifted[7:0]};
      LSU_LBU: data_o = {{(XLEN - 8){1'b0}}, shifted[7:0]};
      LSU_LH:  data_o = {{(XLEN - 16){shifted[15]}}, shifted[15:0]};
      LSU_LHU: data_o = {{(XLEN - 16){1'b0}}, shifted[15:0]};
      LSU_LW:  data_o = shifted;
      default: data_o = '0;  // stores carry no load data
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/lsu_ctrl.sv
// LSU request state machine
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  // Issue
  input  logic             req_valid_i,
  input  lsu_req_t         req_i,
  output logic             req_ready_o,
  // Address unit
  input  logic [PLEN-1:0]  agu_addr_i,
  input  logic             agu_misaligned_i,
  input  logic [XLEN-1:0]  agu_data_i,
  output logic [XLEN-1:0]  agu_rs1_o,
  output logic [XLEN-1:0]  agu_imm_o,
  output logic [XLEN-1:0]  agu_raw_o,
  output lsu_op_e          agu_op_o,
  // Store buffer
  output logic             sb_push_o,
  output mem_wr_t          sb_push_o_data,
  input  logic             sb_full_i,
  input  logic             sb_fwd_hit_i,
  input  logic [XLEN-1:0]  sb_fwd_data_i,
  input  logic             sb_conflict_i,
  input  logic             sb_empty_i,
  // Memory load port
  output logic             ld_valid_o,
  output ld_req_t          ld_o,
  input  logic             ld_ready_i,
  input  logic             ldr_valid_i,
  input  ld_rsp_t          ldr_i,
  // Writeback
  output logic             wb_valid_o,
  output lsu_wb_t          wb_o,
  input  logic             wb_ready_i
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HOLD,
    S_LD_REQ,
    S_LD_RSP,
    S_RESP
  } ctrl_state_e;

  ctrl_state_e     state_q, state_d;
  logic            accept;
  logic [PLEN-1:0] hold_addr_q;
  lsu_op_e         hold_op_q;
  lsu_wb_t         resp_q;

  // ----------------------------
  // Handshakes and datapath steering
  // ----------------------------
  assign req_ready_o = (state_q == S_IDLE) && !flush_i && !(req_i.is_store && sb_full_i);
  assign accept      = req_valid_i && req_ready_o;

  // Idle computes from the issue port, later states replay the held address
  assign agu_rs1_o = (state_q == S_IDLE) ? req_i.rs1 : {{(XLEN - PLEN){1'b0}}, hold_addr_q};
  assign agu_imm_o = (state_q == S_IDLE) ? req_i.imm : '0;
  assign agu_op_o  = (state_q == S_IDLE) ? req_i.op : hold_op_q;
  assign agu_raw_o = (state_q == S_LD_RSP) ? ldr_i.data : sb_fwd_data_i;

  assign sb_push_o           = accept && req_i.is_store && !agu_misaligned_i;
  assign sb_push_o_data.addr = agu_addr_i;
  assign sb_push_o_data.data = req_i.rs2 << {agu_addr_i[1:0], 3'b000};
  assign sb_push_o_data.op   = req_i.op;

  assign ld_valid_o = (state_q == S_LD_REQ);
  assign ld_o.addr  = hold_addr_q;
  assign ld_o.op    = hold_op_q;

  assign wb_valid_o = (state_q == S_RESP);
  assign wb_o       = resp_q;

  // ----------------------------
  // Next state
  // ----------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (accept) begin
          if (!req_i.is_load || agu_misaligned_i || sb_fwd_hit_i) begin
            state_d = S_RESP;
          end else if (sb_conflict_i) begin
            state_d = S_HOLD;
          end else begin
            state_d = S_LD_REQ;
          end
        end
      end
      S_HOLD:   if (sb_empty_i) state_d = S_LD_REQ;
      S_LD_REQ: if (ld_ready_i) state_d = S_LD_RSP;
      S_LD_RSP: if (ldr_valid_i) state_d = S_RESP;
      S_RESP:   if (wb_ready_i) state_d = S_IDLE;
      default:  state_d = S_IDLE;
    endcase
    if (flush_i) begin
      state_d = S_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and response registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_addr_q       <= agu_addr_i;
      hold_op_q         <= req_i.op;
      resp_q.rob_tag    <= req_i.rob_tag;
      resp_q.data       <= '0;
      resp_q.exception  <= 1'b0;
      resp_q.ecause     <= '0;
      if (req_i.is_store && agu_misaligned_i) begin
        resp_q.exception <= 1'b1;
        resp_q.ecause    <= EXC_ST_MISALIGNED;
      end else if (req_i.is_load && agu_misaligned_i) begin
        resp_q.exception <= 1'b1;
        resp_q.ecause    <= EXC_LD_MISALIGNED;
      end else if (req_i.is_load && sb_fwd_hit_i) begin
        resp_q.data <= agu_data_i;
      end
    end
    if (state_q == S_LD_RSP && ldr_valid_i) begin
      resp_q.data      <= ldr_i.err ? '0 : agu_data_i;
      resp_q.exception <= ldr_i.err;
      resp_q.ecause    <= ldr_i.err ? EXC_LD_FAULT : 5'd0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/lsu_pkg.sv
// LSU shared definitions
`default_nettype none

package lsu_pkg;

  // ----------------------------
  // Widths and sizes
  // ----------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned PLEN       = 12;
  localparam int unsigned ROB_IDX_W  = 6;
  localparam int unsigned SB_DEPTH   = 4;
  localparam int unsigned SB_AW      = $clog2(SB_DEPTH);
  localparam int unsigned DMEM_WORDS = 256;
  localparam int unsigned DMEM_AW    = $clog2(DMEM_WORDS);

  // RISC-V exception causes
  localparam logic [4:0] EXC_LD_MISALIGNED = 5'd4;
  localparam logic [4:0] EXC_LD_FAULT      = 5'd5;
  localparam logic [4:0] EXC_ST_MISALIGNED = 5'd6;

  typedef enum logic [2:0] {
    LSU_LB,
    LSU_LBU,
    LSU_LH,
    LSU_LHU,
    LSU_LW,
    LSU_SB,
    LSU_SH,
    LSU_SW
  } lsu_op_e;

  // ----------------------------
  // Bus payloads
  // ----------------------------
  typedef struct packed {
    lsu_op_e                op;
    logic                   is_load;
    logic                   is_store;
    logic [XLEN-1:0]        rs1;
    logic [XLEN-1:0]        rs2;
    logic [XLEN-1:0]        imm;
    logic [ROB_IDX_W-1:0]   rob_tag;
  } lsu_req_t;

  typedef struct packed {
    logic [ROB_IDX_W-1:0]   rob_tag;
    logic [XLEN-1:0]        data;
    logic                   exception;
    logic [4:0]             ecause;
  } lsu_wb_t;

  // Data is lane aligned, byte k of the word sits in bits [8k+7:8k]
  typedef struct packed {
    logic [PLEN-1:0]        addr;
    logic [XLEN-1:0]        data;
    lsu_op_e                op;
  } mem_wr_t;

  typedef struct packed {
    logic [PLEN-1:0]        addr;
    lsu_op_e                op;
  } ld_req_t;

  typedef struct packed {
    logic [XLEN-1:0]        data;
    logic                   err;
  } ld_rsp_t;

  // Log2 of the access size in bytes
  function automatic logic [1:0] op_size(input lsu_op_e op);
    case (op)
      LSU_LB, LSU_LBU, LSU_SB: op_size = 2'd0;
      LSU_LH, LSU_LHU, LSU_SH: op_size = 2'd1;
      default:                 op_size = 2'd2;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- rtl/lsu_top.sv
// Load/store unit top level
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      commit_i,
  input  logic      req_valid_i,
  input  lsu_req_t  req_i,
  output logic      req_ready_o,
  output logic      wb_valid_o,
  output lsu_wb_t   wb_o,
  input  logic      wb_ready_i
);

  logic [PLEN-1:0] agu_addr;
  logic            agu_misaligned;
  logic [XLEN-1:0] agu_data, agu_raw, agu_rs1, agu_imm;
  lsu_op_e         agu_op;
  logic            sb_push, sb_full, sb_empty, sb_fwd_hit, sb_conflict;
  mem_wr_t         sb_push_data;
  logic [XLEN-1:0] sb_fwd_data;
  logic            ld_valid, ld_ready, ldr_valid;
  ld_req_t         ld_req;
  ld_rsp_t         ldr;
  logic            wr_valid, wr_ready;
  mem_wr_t         wr;

  lsu_ctrl i_ctrl (
    .clk_i, .rst_ni, .flush_i, .req_valid_i, .req_i, .req_ready_o,
    .agu_addr_i(agu_addr), .agu_misaligned_i(agu_misaligned), .agu_data_i(agu_data),
    .agu_rs1_o(agu_rs1), .agu_imm_o(agu_imm), .agu_raw_o(agu_raw), .agu_op_o(agu_op),
    .sb_push_o(sb_push), .sb_push_o_data(sb_push_data), .sb_full_i(sb_full),
    .sb_fwd_hit_i(sb_fwd_hit), .sb_fwd_data_i(sb_fwd_data), .sb_conflict_i(sb_conflict),
    .sb_empty_i(sb_empty),
    .ld_valid_o(ld_valid), .ld_o(ld_req), .ld_ready_i(ld_ready),
    .ldr_valid_i(ldr_valid), .ldr_i(ldr),
    .wb_valid_o, .wb_o, .wb_ready_i
  );

  lsu_agu i_agu (
    .op_i(agu_op), .rs1_i(agu_rs1), .imm_i(agu_imm), .raw_i(agu_raw),
    .addr_o(agu_addr), .misaligned_o(agu_misaligned), .data_o(agu_data)
  );

  // Forwarding query follows whatever address the AGU is forming
  store_buffer i_sb (
    .clk_i, .rst_ni, .flush_i,
    .push_i(sb_push), .push_data_i(sb_push_data), .full_o(sb_full), .empty_o(sb_empty),
    .commit_i, .query_addr_i(agu_addr), .query_op_i(agu_op),
    .fwd_hit_o(sb_fwd_hit), .fwd_data_o(sb_fwd_data), .conflict_o(sb_conflict),
    .wr_valid_o(wr_valid), .wr_o(wr), .wr_ready_i(wr_ready)
  );

  dmem i_dmem (
    .clk_i, .rst_ni,
    .ld_valid_i(ld_valid), .ld_i(ld_req), .ld_ready_o(ld_ready),
    .ldr_valid_o(ldr_valid), .ldr_o(ldr),
    .wr_valid_i(wr_valid), .wr_i(wr), .wr_ready_o(wr_ready)
  );

endmodule

`default_nettype wire

//--- rtl/store_buffer.sv
// LSU store buffer
`timescale 1ns/1ps
`default_nettype none

module store_buffer
  import lsu_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             push_i,
  input  mem_wr_t          push_data_i,
  output logic             full_o,
  output logic             empty_o,
  input  logic             commit_i,
  input  logic [PLEN-1:0]  query_addr_i,
  input  lsu_op_e          query_op_i,
  output logic             fwd_hit_o,
  output logic [XLEN-1:0]  fwd_data_o,
  output logic             conflict_o,
  output logic             wr_valid_o,
  output mem_wr_t          wr_o,
  input  logic             wr_ready_i
);

  // Pointers carry one wrap bit above the index
  logic [SB_AW:0] head_q, cmt_q, tail_q;
  logic [SB_AW:0] cmt_d;
  logic [SB_AW:0] count;
  mem_wr_t        buf_q [SB_DEPTH];
  logic           same_word;

  assign count   = tail_q - head_q;
  assign full_o  = (count == (SB_AW + 1)'(SB_DEPTH));
  assign empty_o = (head_q == tail_q);

  // Committed entries drain from the head
  assign wr_valid_o = (head_q != cmt_q);
  assign wr_o       = buf_q[head_q[SB_AW-1:0]];

  assign cmt_d = (commit_i && cmt_q != tail_q) ? cmt_q + 1'b1 : cmt_q;

  // ----------------------------
  // Forwarding search
  // ----------------------------
  // Walks oldest to youngest so the youngest same-word store decides
  always_comb begin
    logic [SB_AW:0] idx;
    mem_wr_t        ent;
    fwd_hit_o  = 1'b0;
    fwd_data_o = '0;
    same_word  = 1'b0;
    for (int i = 0; i < SB_DEPTH; i++) begin
      idx = head_q + (SB_AW + 1)'(i);
      ent = buf_q[idx[SB_AW-1:0]];
      if ((SB_AW + 1)'(i) < count && ent.addr[PLEN-1:2] == query_addr_i[PLEN-1:2]) begin
        same_word = 1'b1;
        if (ent.addr == query_addr_i && op_size(ent.op) >= op_size(query_op_i)) begin
          fwd_hit_o  = 1'b1;
          fwd_data_o = ent.data;
        end else begin
          fwd_hit_o = 1'b0;
        end
      end
    end
  end

  assign conflict_o = same_word && !fwd_hit_o;

  // ----------------------------
  // Pointer update
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '0;
      cmt_q  <= '0;
      tail_q <= '0;
    end else begin
      cmt_q <= cmt_d;
      if (wr_valid_o && wr_ready_i) begin
        head_q <= head_q + 1'b1;
      end
      // Flush drops everything younger than the commit point
      if (flush_i) begin
        tail_q <= cmt_d;
      end else if (push_i && !full_o) begin
        tail_q <= tail_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !full_o && !flush_i) begin
      buf_q[tail_q[SB_AW-1:0]] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lsu_top --Mdir obj_dir -o tb_lsu_top -f flist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_lsu_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi

if ! grep -q "TESTS PASSED" sim.log; then
  echo "no pass message found in sim.log"
  exit 1
fi

exit 0

//--- sim/tb_lsu_top.sv
// LSU top level testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top
  import lsu_pkg::*;
;

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_OPS     = 48;   // requests issued over all tests, rounded up
  localparam int OP_TIMEOUT  = 100;  // cycles one handshake may take
  localparam int WATCHDOG_NS = (NUM_OPS * 200 + 10) * CLK_PERIOD;

  // Model of one buffered store
  typedef struct packed {
    logic [11:0] addr;
    logic [31:0] data;
    logic [2:0]  nbytes;
    logic        committed;
  } sb_ent_t;

  logic     clk, rst_n, flush, commit, req_valid, req_ready, wb_valid, wb_ready;
  lsu_req_t req;
  lsu_wb_t  wb;
  lsu_wb_t  exp_wb;

  logic [31:0] ref_mem [256];
  sb_ent_t     sb_q [$];
  logic [5:0]  tag;
  bit          random_ready;
  int          errors, checks, tests, err_base;

  lsu_top i_dut (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .commit_i(commit),
    .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
    .wb_valid_o(wb_valid), .wb_o(wb), .wb_ready_i(wb_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------
  // Assertions
  // ----------------------------
  assert property (@(posedge clk) disable iff (!rst_n) (wb_valid && wb_ready) |-> (wb == exp_wb))
    else begin
      errors++;
      $display("mismatch wb_o: got %h expected %h", $sampled(wb), $sampled(exp_wb));
    end

  assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> !req_ready)
    else begin
      errors++;
      $display("mismatch req_ready_o: got 1 expected 0 while wb_valid_o is high");
    end

  // Writeback must hold still while stalled
  assert property (@(posedge clk) disable iff (!rst_n)
      (wb_valid && !wb_ready && !flush) |=> (wb_valid && $stable(wb)))
    else begin
      errors++;
      $display("writeback changed or dropped while wb_ready_i was low");
    end

  assert property (@(posedge clk) disable iff (!rst_n) flush |=> !wb_valid)
    else begin
      errors++;
      $display("writeback still valid in the cycle after a flush");
    end

  // ----------------------------
  // Reference model
  // ----------------------------
  function automatic int op_bytes(input lsu_op_e op);
    case (op)
      LSU_LB, LSU_LBU, LSU_SB: return 1;
      LSU_LH, LSU_LHU, LSU_SH: return 2;
      default:                 return 4;
    endcase
  endfunction

  function automatic bit is_store_op(input lsu_op_e op);
    return op == LSU_SB || op == LSU_SH || op == LSU_SW;
  endfunction

  function automatic logic [31:0] extend_load(input logic [31:0] v, input int nb, input bit sgn);
    case (nb)
      1:       return sgn ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
      2:       return sgn ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
      default: return v;
    endcase
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] word, input logic [1:0] off,
                                              input logic [31:0] data, input int nb);
    for (int b = 0; b < nb; b++) begin
      word[8 * (int'(off) + b) +: 8] = data[8 * b +: 8];
    end
    return word;
  endfunction

  // Expected writeback for an op at the given byte address
  function automatic lsu_wb_t predict(input lsu_op_e op, input logic [11:0] addr);
    lsu_wb_t     r;
    int          nb;
    bit          hit;
    bit          sgn;
    logic [31:0] fwd;
    logic [31:0] word;
    r.rob_tag   = tag;
    r.data      = '0;
    r.exception = 1'b0;
    r.ecause    = '0;
    nb  = op_bytes(op);
    sgn = (op == LSU_LB || op == LSU_LH);
    hit = 1'b0;
    fwd = '0;
    if (int'(addr) % nb != 0) begin
      r.exception = 1'b1;
      r.ecause    = is_store_op(op) ? 5'd6 : 5'd4;
      return r;
    end
    if (is_store_op(op)) begin
      return r;
    end
    // Youngest store to the same word decides
    foreach (sb_q[i]) begin
      if (sb_q[i].addr[11:2] == addr[11:2]) begin
        hit = (sb_q[i].addr == addr) && (int'(sb_q[i].nbytes) >= nb);
        if (hit) begin
          fwd = sb_q[i].data;
        end
      end
    end
    if (hit) begin
      r.data = extend_load(fwd, nb, sgn);
    end else if (addr >= 12'd1024) begin
      r.exception = 1'b1;
      r.ecause    = 5'd5;
    end else begin
      // A conflicting load only proceeds once every buffered store has landed
      word = ref_mem[addr[9:2]];
      foreach (sb_q[i]) begin
        if (sb_q[i].addr[11:2] == addr[11:2]) begin
          word = merge_bytes(word, sb_q[i].addr[1:0], sb_q[i].data, int'(sb_q[i].nbytes));
        end
      end
      r.data = extend_load(word >> {addr[1:0], 3'b000}, nb, sgn);
    end
    return r;
  endfunction

  // ----------------------------
  // Stimulus tasks
  // ----------------------------
  // All tasks start and end 1 ns after a rising edge
  task automatic run_op(input lsu_op_e op, input logic [31:0] rs1, input logic [31:0] imm,
                        input logic [31:0] rs2, input bit flush_at_wb);
    logic [11:0] addr;
    sb_ent_t     ent;
    int          n;
    addr   = 12'(rs1 + imm);
    exp_wb = predict(op, addr);
    if (is_store_op(op) && !exp_wb.exception) begin
      ent.addr      = addr;
      ent.data      = rs2;
      ent.nbytes    = 3'(op_bytes(op));
      ent.committed = 1'b0;
      sb_q.push_back(ent);
    end
    req.op       = op;
    req.is_load  = !is_store_op(op);
    req.is_store = is_store_op(op);
    req.rs1      = rs1;
    req.rs2      = rs2;
    req.imm      = imm;
    req.rob_tag  = tag;
    req_valid    = 1'b1;
    if (flush_at_wb) begin
      wb_ready = 1'b0;
    end
    n = 0;
    @(negedge clk);
    while (!req_ready && n < OP_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    if (n >= OP_TIMEOUT) begin
      errors++;
      $display("timeout: request %0d was never accepted", tag);
      return;
    end
    n = 0;
    forever begin
      if (random_ready && !flush_at_wb) begin
        wb_ready = ($urandom % 3 != 0);
      end
      @(negedge clk);
      if (wb_valid && (wb_ready || flush_at_wb)) break;
      n++;
      if (n >= OP_TIMEOUT) break;
      @(posedge clk);
      #1;
    end
    if (!wb_valid) begin
      errors++;
      $display("timeout: no writeback for request %0d", tag);
    end else if (flush_at_wb) begin
      @(posedge clk);
      #1;
      flush_pulse();
    end else begin
      @(posedge clk);
      #1;
      checks++;
    end
    wb_ready = 1'b1;
    tag++;
  endtask

  task automatic commit_pulse();
    commit = 1'b1;
    foreach (sb_q[i]) begin
      if (!sb_q[i].committed) begin
        sb_q[i].committed = 1'b1;
        break;
      end
    end
    @(posedge clk);
    #1;
    commit = 1'b0;
  endtask

  task automatic commit_all();
    int pending;
    pending = 0;
    foreach (sb_q[i]) begin
      if (!sb_q[i].committed) pending++;
    end
    repeat (pending) commit_pulse();
  endtask

  task automatic flush_pulse();
    sb_ent_t ent;
    flush = 1'b1;
    while (sb_q.size() > 0 && !sb_q[sb_q.size() - 1].committed) begin
      ent = sb_q.pop_back();
    end
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  // Buffer drains one committed entry per cycle
  task automatic drain_wait();
    sb_ent_t ent;
    repeat (sb_q.size() + 2) @(posedge clk);
    #1;
    while (sb_q.size() > 0 && sb_q[0].committed) begin
      ent = sb_q.pop_front();
      if (ent.addr < 12'd1024) begin
        ref_mem[ent.addr[9:2]] = merge_bytes(ref_mem[ent.addr[9:2]], ent.addr[1:0], ent.data,
                                             int'(ent.nbytes));
      end
    end
  endtask

  task automatic close_test(input string name);
    tests++;
    if (errors == err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - err_base);
    end
    err_base = errors;
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    commit = 1'b0;
    req_valid = 1'b0;
    req = '0;
    wb_ready = 1'b1;
    tag = '0;
    random_ready = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    err_base = 0;
    void'($urandom(33072));
    for (int w = 0; w < 256; w++) begin
      ref_mem[w] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // Load widths and extension from memory
    run_op(LSU_SW, 32'h100, 32'h0, 32'h80F1_7F82, 0);
    run_op(LSU_SH, 32'h110, 32'hFFFF_FFFE, 32'h1234_BEEF, 0);
    commit_all();
    drain_wait();
    run_op(LSU_LW, 32'h100, 32'h0, 32'h0, 0);
    run_op(LSU_LB, 32'h0F0, 32'h10, 32'h0, 0);
    run_op(LSU_LBU, 32'h100, 32'h1, 32'h0, 0);
    run_op(LSU_LB, 32'h100, 32'h2, 32'h0, 0);
    run_op(LSU_LBU, 32'h100, 32'h3, 32'h0, 0);
    run_op(LSU_LH, 32'h100, 32'h0, 32'h0, 0);
    run_op(LSU_LHU, 32'h100, 32'h2, 32'h0, 0);
    run_op(LSU_LH, 32'h100, 32'h2, 32'h0, 0);
    run_op(LSU_LH, 32'h110, 32'hFFFF_FFFE, 32'h0, 0);
    run_op(LSU_LW, 32'h10C, 32'h0, 32'h0, 0);
    close_test("load widths");

    // Forwarding, youngest store wins, conflicting load waits for the drain
    run_op(LSU_SW, 32'h200, 32'h0, 32'h1234_5678, 0);
    run_op(LSU_LW, 32'h200, 32'h0, 32'h0, 0);
    run_op(LSU_LB, 32'h200, 32'h0, 32'h0, 0);
    run_op(LSU_SW, 32'h208, 32'h0, 32'h1111_1111, 0);
    run_op(LSU_SW, 32'h208, 32'h0, 32'h2222_2222, 0);
    run_op(LSU_LW, 32'h208, 32'h0, 32'h0, 0);
    run_op(LSU_SB, 32'h204, 32'h0, 32'h0000_00AB, 0);
    fork
      run_op(LSU_LW, 32'h204, 32'h0, 32'h0, 0);
      begin
        repeat (4) @(posedge clk);
        #1;
        commit_all();
      end
    join
    drain_wait();
    close_test("forwarding");

    // Misaligned accesses, the faulting store must not reach memory
    run_op(LSU_LH, 32'h101, 32'h0, 32'h0, 0);
    run_op(LSU_LW, 32'h100, 32'h2, 32'h0, 0);
    run_op(LSU_LHU, 32'h103, 32'h0, 32'h0, 0);
    run_op(LSU_SH, 32'h103, 32'h0, 32'h5555_5555, 0);
    run_op(LSU_SW, 32'h102, 32'h0, 32'hDEAD_BEEF, 0);
    commit_pulse();
    drain_wait();
    run_op(LSU_LW, 32'h100, 32'h0, 32'h0, 0);
    close_test("misaligned");

    // Access fault range
    run_op(LSU_LW, 32'h400, 32'h0, 32'h0, 0);
    run_op(LSU_LB, 32'h7FF, 32'h0, 32'h0, 0);
    run_op(LSU_LW, 32'h3FC, 32'h4, 32'h0, 0);
    run_op(LSU_LW, 32'h3FC, 32'h0, 32'h0, 0);
    close_test("access fault");

    // Random writeback back-pressure
    random_ready = 1'b1;
    for (int i = 0; i < 4; i++) begin
      run_op(LSU_SW, 32'h300 + 32'(4 * i), 32'h0, $urandom, 0);
    end
    commit_all();
    drain_wait();
    for (int i = 0; i < 4; i++) begin
      run_op(LSU_LW, 32'h300 + 32'(4 * i), 32'h0, 32'h0, 0);
    end
    run_op(LSU_LBU, 32'h301, 32'h0, 32'h0, 0);
    random_ready = 1'b0;
    close_test("back-pressure");

    // Flush drops uncommitted stores and the pending writeback
    run_op(LSU_SW, 32'h044, 32'h0, 32'hCAFE_0001, 0);
    commit_all();
    drain_wait();
    run_op(LSU_SW, 32'h040, 32'h0, 32'h0BAD_F00D, 0);
    run_op(LSU_SW, 32'h044, 32'h0, 32'h55AA_55AA, 0);
    commit_pulse();
    run_op(LSU_SB, 32'h048, 32'h0, 32'h0000_0077, 1);
    drain_wait();
    run_op(LSU_LW, 32'h040, 32'h0, 32'h0, 0);
    run_op(LSU_LW, 32'h044, 32'h0, 32'h0, 0);
    run_op(LSU_LW, 32'h048, 32'h0, 32'h0, 0);
    close_test("flush");

    $display("%0d tests run, %0d writebacks checked, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
